//--- program.hex
// One 32-bit instruction word per line, word 0 first, assembly after the word
// Registers start at zero, R8 is the base address for the data RAM
E3A0105A // MOV  R1, #0x5A
E3A030C3 // MOV  R3, #0xC3
E3A0200F // MOV  R2, #0x0F
E3A08040 // MOV  R8, #0x40
E0014003 // AND  R4, R1, R3      R3 at distance 3
E22250FF // EOR  R5, R2, #0xFF   R2 at distance 3
E1816002 // ORR  R6, R1, R2
E241701A // SUB  R7, R1, #0x1A
E0879007 // ADD  R9, R7, R7      distance 1
E049A002 // SUB  R10, R9, R2     distance 1
E1A0B004 // MOV  R11, R4
E28AC001 // ADD  R12, R10, #1    distance 2
E588C000 // STR  R12, [R8, #0]   store data at distance 1
E5885004 // STR  R5, [R8, #4]
E598D000 // LDR  R13, [R8, #0]
E598E004 // LDR  R14, [R8, #4]
E04E000D // SUB  R0, R14, R13    load use
13A00077 // MOVNE R0, #0x77      not always, no-op
E081F002 // ADD  R15, R1, R2     writes R15, no-op
E2610001 // RSB  R0, R1, #1      unknown opcode, no-op
// Zero padding, words 20 to 63
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000

//--- sources.f
arm_pkg.sv
stage_reg.sv
fetch_stage.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
arm_core.sv
tb_arm_core.sv

//--- run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_arm_core -f sources.f

# Output goes to the screen and to sim.log
./obj_dir/Vtb_arm_core | tee sim.log

if grep -qx "Test OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- tb_arm_core.sv
`default_nettype none

module tb_arm_core;

	timeunit 1ns;
	timeprecision 1ps;

	logic             clk;
	logic             rst_n;
	arm_pkg::retire_t retire;                          // Only visible DUT output

	arm_pkg::word_t    prog [arm_pkg::imem_depth];     // Own copy of the ROM image
	arm_pkg::reg_idx_t exp_dest [arm_pkg::imem_depth]; // Expected retire stream
	arm_pkg::word_t    exp_value [arm_pkg::imem_depth];
	int                exp_instr [arm_pkg::imem_depth]; // Source word of each event
	int                exp_count;
	int                retire_idx;                     // Retire events seen so far
	int                edges_since_reset;
	int                check_errors;
	int                tests_passed;
	int                tests_failed;
	int                errs_before;
	logic              timed_out;

	arm_core i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.retire (retire)
	);

	always #5 clk = ~clk;                              // 10 ns period

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			edges_since_reset <= 0;
			retire_idx        <= 0;
		end else begin
			edges_since_reset <= edges_since_reset + 1;
			if (retire.valid) begin
				retire_idx <= retire_idx + 1;          // Points at next expected event
			end
		end
	end

	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire.valid)
		else begin
			check_errors++;
			$display("Retire event at %0t while reset was held", $time);
		end

	// Fill takes four edges after release
	a_no_early_retire: assert property (
		@(posedge clk) disable iff (!rst_n) (edges_since_reset < 4) |-> !retire.valid
	) else begin
		check_errors++;
		$display("Retire event at %0t before the pipeline could fill", $time);
	end

	a_first_on_time: assert property (
		@(posedge clk) disable iff (!rst_n) (edges_since_reset == 4) |-> retire.valid
	) else begin
		check_errors++;
		$display("First instruction did not retire 5 edges after fetch, at %0t", $time);
	end

	a_no_extra: assert property (
		@(posedge clk) disable iff (!rst_n) retire.valid |-> (retire_idx < exp_count)
	) else begin
		check_errors++;
		$display("Retire event at %0t beyond the %0d the program produces", $time, exp_count);
	end

	a_match: assert property (
		@(posedge clk) disable iff (!rst_n)
		(retire.valid && retire_idx < exp_count) |->
			(retire.dest == exp_dest[retire_idx] && retire.value == exp_value[retire_idx])
	) else begin
		check_errors++;
		$display("Mismatch at %0t: event %0d expected R%0d = %h, got R%0d = %h", $time,
			$sampled(retire_idx), exp_dest[$sampled(retire_idx)],
			exp_value[$sampled(retire_idx)], $sampled(retire.dest), $sampled(retire.value));
	end

	task automatic push_expected(input int instr, input arm_pkg::reg_idx_t rd,
		input arm_pkg::word_t value);
		exp_instr[exp_count] = instr;
		exp_dest[exp_count]  = rd;
		exp_value[exp_count] = value;
		exp_count++;
	endtask

	// Architectural model stepping one word at a time in program order
	task automatic run_model();
		arm_pkg::word_t    regs [16];
		arm_pkg::word_t    dmem [arm_pkg::dmem_depth];
		arm_pkg::word_t    ins;
		arm_pkg::word_t    op2;
		arm_pkg::word_t    result;
		arm_pkg::word_t    addr;
		arm_pkg::reg_idx_t rn;
		arm_pkg::reg_idx_t rd;
		logic              known;
		for (int r = 0; r < 16; r++) begin
			regs[r] = '0;
		end
		for (int m = 0; m < arm_pkg::dmem_depth; m++) begin
			dmem[m] = '0;
		end
		exp_count = 0;
		for (int k = 0; k < arm_pkg::imem_depth; k++) begin
			ins = prog[k];
			rn  = ins[19:16];
			rd  = ins[15:12];
			if (ins[31:28] == arm_pkg::cond_al && ins[27:26] == 2'b00) begin
				op2   = ins[25] ? arm_pkg::word_t'(ins[7:0]) : regs[ins[3:0]]; // Imm or Rm
				known = 1'b1;
				result = '0;
				case (ins[24:21])
					arm_pkg::op_and: result = regs[rn] & op2;
					arm_pkg::op_eor: result = regs[rn] ^ op2;
					arm_pkg::op_sub: result = regs[rn] - op2;
					arm_pkg::op_add: result = regs[rn] + op2;
					arm_pkg::op_orr: result = regs[rn] | op2;
					arm_pkg::op_mov: result = op2;
					default:         known = 1'b0;        // Unknown opcode is a no-op
				endcase
				if (known && rd != arm_pkg::pc_reg) begin
					regs[rd] = result;
					push_expected(k, rd, result);
				end
			end else if (ins[31:28] == arm_pkg::cond_al && ins[27:26] == 2'b01) begin
				addr = regs[rn] + arm_pkg::word_t'(ins[11:0]); // Rn plus 12-bit offset
				if (!ins[20]) begin
					dmem[addr[7:2]] = regs[rd];                // STR does not retire
				end else if (rd != arm_pkg::pc_reg) begin
					regs[rd] = dmem[addr[7:2]];
					push_expected(k, rd, regs[rd]);
				end
			end
		end
	endtask

	function automatic int events_before(input int instr_limit);
		int n;
		n = 0;
		for (int i = 0; i < exp_count; i++) begin
			if (exp_instr[i] < instr_limit) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic wait_retires(input int target, input string behavior);
		int cycles;
		cycles = 0;
		while (retire_idx < target && cycles < 500) begin
			@(posedge clk);
			#1;                                         // Past the counter update
			cycles++;
		end
		if (retire_idx < target) begin
			timed_out = 1'b1;
			$display("Timeout: %s stalled, %0d of %0d retire events after 500 cycles",
				behavior, retire_idx, target);
		end
	endtask

	task automatic report_result(input string name, input int errs_at_start);
		if (timed_out || check_errors != errs_at_start) begin
			tests_failed++;
			$display("[%0t] %s: fail, %0d check errors", $time, name,
				check_errors - errs_at_start);
		end else begin
			tests_passed++;
			$display("[%0t] %s: pass", $time, name);
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		check_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		$readmemh("program.hex", prog);
		run_model();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		errs_before = 0;
		wait_retires(1, "first retire after reset");
		report_result("reset and first retire", errs_before);
		if (!timed_out) begin
			errs_before = check_errors;
			wait_retires(events_before(8), "independent data processing");  // Words 0-7
			report_result("independent data processing", errs_before);
		end
		if (!timed_out) begin
			errs_before = check_errors;
			wait_retires(events_before(12), "dependent chains");            // Words 8-11
			report_result("dependent chains at distance 1 to 3", errs_before);
		end
		if (!timed_out) begin
			errs_before = check_errors;
			wait_retires(events_before(17), "store and load");              // Words 12-16
			report_result("store then load", errs_before);
		end
		if (!timed_out) begin
			errs_before = check_errors;
			wait_retires(exp_count, "no-op filtering");
			if (!timed_out) begin
				for (int i = 0; i < 50; i++) begin
					@(posedge clk);                     // Quiet tail after the program
					#1;
				end
				a_event_count: assert (retire_idx == exp_count) else begin
					check_errors++;
					$display("Mismatch at %0t: retire count expected %0d, got %0d", $time,
						exp_count, retire_idx);
				end
			end
			report_result("no-op filtering and quiet tail", errs_before);
		end
		$display("Summary: %0d passed, %0d failed, %0d check errors", tests_passed,
			tests_failed, check_errors);
		if (tests_failed == 0 && check_errors == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- arm_core.sv
`default_nettype none

module arm_core (
	input  logic             clk,
	input  logic             rst_n,
	output arm_pkg::retire_t retire
);

	arm_pkg::if_id_t   if_d, if_q;
	arm_pkg::id_ex_t   id_d, id_q;
	arm_pkg::ex_mem_t  ex_d, ex_q;
	arm_pkg::mem_wb_t  mem_d, mem_q;
	arm_pkg::reg_idx_t src1, src2;
	logic              src1_used, src2_used;
	logic              stall;

	fetch_stage i_fetch (
		.clk    (clk),
		.rst_n  (rst_n),
		.freeze (stall),
		.if_out (if_d)
	);

	stage_reg #(.payload_t(arm_pkg::if_id_t)) i_if_id (
		.clk(clk), .rst_n(rst_n), .hold(stall), .bubble(1'b0), .d(if_d), .q(if_q)
	);

	decode_stage i_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.if_in     (if_q),
		.wb_in     (mem_q),
		.src1      (src1),
		.src1_used (src1_used),
		.src2      (src2),
		.src2_used (src2_used),
		.id_out    (id_d),
		.retire    (retire)
	);

	hazard_unit i_hazard (
		.src1      (src1),
		.src1_used (src1_used),
		.src2      (src2),
		.src2_used (src2_used),
		.exe_dest  (id_q.dest),
		.exe_wb_en (id_q.wb_en),
		.mem_dest  (ex_q.dest),
		.mem_wb_en (ex_q.wb_en),
		.stall     (stall)
	);

	stage_reg #(.payload_t(arm_pkg::id_ex_t)) i_id_ex (
		.clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(stall), .d(id_d), .q(id_q)
	);

	execute_stage i_execute (.id_in(id_q), .ex_out(ex_d));

	stage_reg #(.payload_t(arm_pkg::ex_mem_t)) i_ex_mem (
		.clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0), .d(ex_d), .q(ex_q)
	);

	memory_stage i_memory (.clk(clk), .ex_in(ex_q), .mem_out(mem_d));

	stage_reg #(.payload_t(arm_pkg::mem_wb_t)) i_mem_wb (
		.clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0), .d(mem_d), .q(mem_q)
	);

endmodule

`default_nettype wire

//--- memory_stage.sv
`default_nettype none

module memory_stage (
	input  logic             clk,
	input  arm_pkg::ex_mem_t ex_in,
	output arm_pkg::mem_wb_t mem_out
);

	arm_pkg::word_t              ram [arm_pkg::dmem_depth]; // Data memory
	logic [arm_pkg::dmem_aw-1:0] idx;                       // Word index

	assign idx = ex_in.alu_result[arm_pkg::dmem_aw+1:2];    // Address bits 7:2

	always_ff @(posedge clk) begin
		if (ex_in.mem_w_en) begin
			ram[idx] <= ex_in.st_val;                       // Word store on the edge
		end
	end

	always_comb begin
		mem_out.wb_en      = ex_in.wb_en;
		mem_out.mem_r_en   = ex_in.mem_r_en;
		mem_out.alu_result = ex_in.alu_result;
		mem_out.mem_data   = ex_in.mem_r_en ? ram[idx] : '0; // Async read
		mem_out.dest       = ex_in.dest;
	end

	// Word accesses only
	a_word_aligned: assert property (
		@(posedge clk)
		(ex_in.mem_r_en || ex_in.mem_w_en) |-> (ex_in.alu_result[1:0] == 2'b00)
	) else $error("Unaligned data access at %h", ex_in.alu_result);

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
	input  arm_pkg::id_ex_t  id_in,
	output arm_pkg::ex_mem_t ex_out
);

	logic           mem_access;   // LDR or STR
	arm_pkg::word_t op2;          // Second ALU operand
	arm_pkg::word_t alu_out;
	arm_pkg::word_t addr;         // Rn plus 12-bit offset

	assign mem_access = id_in.mem_r_en || id_in.mem_w_en;

	// No rotation, 8-bit imm zero-extended
	assign op2 = id_in.imm_en ? arm_pkg::word_t'(id_in.imm[7:0]) : id_in.val_rm;

	always_comb begin
		case (id_in.alu_op)
			arm_pkg::op_and: alu_out = id_in.val_rn & op2;
			arm_pkg::op_eor: alu_out = id_in.val_rn ^ op2;
			arm_pkg::op_sub: alu_out = id_in.val_rn - op2;
			arm_pkg::op_add: alu_out = id_in.val_rn + op2;
			arm_pkg::op_orr: alu_out = id_in.val_rn | op2;
			arm_pkg::op_mov: alu_out = op2;            // Rn ignored
			default:         alu_out = '0;
		endcase
	end

	assign addr = id_in.val_rn + arm_pkg::word_t'(id_in.imm); // Full 12 bits, add only

	always_comb begin
		ex_out.wb_en      = id_in.wb_en;
		ex_out.mem_r_en   = id_in.mem_r_en;
		ex_out.mem_w_en   = id_in.mem_w_en;
		ex_out.alu_result = mem_access ? addr : alu_out;
		ex_out.st_val     = id_in.val_rm;              // Rd value for STR
		ex_out.dest       = id_in.dest;
	end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  arm_pkg::if_id_t   if_in,
	input  arm_pkg::mem_wb_t  wb_in,      // From mem_wb register
	output arm_pkg::reg_idx_t src1,
	output logic              src1_used,
	output arm_pkg::reg_idx_t src2,
	output logic              src2_used,
	output arm_pkg::id_ex_t   id_out,
	output arm_pkg::retire_t  retire
);

	arm_pkg::word_t    instr;
	logic [3:0]        cond;
	logic [1:0]        mode;
	logic              imm_bit;           // Bit 25
	logic [3:0]        opcode;
	logic              load_bit;          // L bit 20 of LDR/STR
	arm_pkg::reg_idx_t rn;
	arm_pkg::reg_idx_t rd;
	arm_pkg::reg_idx_t rm;
	logic              is_dp;
	logic              is_mem;
	logic              op_known;
	logic              writes_rd;
	logic              issue;             // Not a no-op
	arm_pkg::word_t    rf [arm_pkg::reg_count];
	arm_pkg::word_t    wb_value;
	arm_pkg::word_t    val_rn;
	arm_pkg::word_t    val_rm;

	// Field split
	assign instr    = if_in.instr;
	assign cond     = instr[31:28];
	assign mode     = instr[27:26];
	assign imm_bit  = instr[25];
	assign opcode   = instr[24:21];
	assign load_bit = instr[20];
	assign rn       = instr[19:16];
	assign rd       = instr[15:12];
	assign rm       = instr[3:0];

	assign is_dp  = (mode == arm_pkg::mode_dp);
	assign is_mem = (mode == arm_pkg::mode_mem);

	always_comb begin
		case (opcode)
			arm_pkg::op_and, arm_pkg::op_eor, arm_pkg::op_sub,
			arm_pkg::op_add, arm_pkg::op_orr, arm_pkg::op_mov: op_known = 1'b1;
			default:                                           op_known = 1'b0;
		endcase
	end

	// No-op on bubble, cond not AL, unknown op or write to R15
	assign writes_rd = is_dp || (is_mem && load_bit);
	assign issue = if_in.valid && (cond == arm_pkg::cond_al) &&
		((is_dp && op_known) || is_mem) &&
		!(writes_rd && (rd == arm_pkg::pc_reg));

	// Sources for hazard check and RF read
	assign src1      = rn;
	assign src1_used = issue && !(is_dp && (opcode == arm_pkg::op_mov)); // MOV has no Rn
	assign src2      = (is_mem && !load_bit) ? rd : rm;                  // STR data in Rd
	assign src2_used = issue && (is_mem ? !load_bit : !imm_bit);

	// Writeback select and write-through read
	assign wb_value = wb_in.mem_r_en ? wb_in.mem_data : wb_in.alu_result;
	assign val_rn = (wb_in.wb_en && (wb_in.dest == src1)) ? wb_value : rf[src1];
	assign val_rm = (wb_in.wb_en && (wb_in.dest == src2)) ? wb_value : rf[src2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < arm_pkg::reg_count; i++) begin
				rf[i] <= '0;                     // All registers start at zero
			end
		end else if (wb_in.wb_en) begin
			rf[wb_in.dest] <= wb_value;          // Same edge as retire
		end
	end

	// Zero payload when not issued
	always_comb begin
		id_out = '0;
		if (issue) begin
			id_out.wb_en    = writes_rd;
			id_out.mem_r_en = is_mem && load_bit;
			id_out.mem_w_en = is_mem && !load_bit;
			id_out.alu_op   = is_mem ? arm_pkg::op_add : arm_pkg::alu_op_e'(opcode);
			id_out.imm_en   = is_mem || imm_bit;       // Offset is always immediate
			id_out.imm      = instr[11:0];
			id_out.val_rn   = val_rn;
			id_out.val_rm   = val_rm;
			id_out.dest     = rd;
		end
	end

	always_comb begin
		retire.valid = wb_in.wb_en;
		retire.dest  = wb_in.dest;
		retire.value = wb_value;
	end

	// R15 filtering happens four stages earlier
	a_no_pc_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_in.wb_en |-> (wb_in.dest != arm_pkg::pc_reg)
	) else $error("Register 15 written back");

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  arm_pkg::reg_idx_t src1,        // Rn of decode
	input  logic              src1_used,
	input  arm_pkg::reg_idx_t src2,        // Rm, or Rd for STR
	input  logic              src2_used,
	input  arm_pkg::reg_idx_t exe_dest,    // id_ex register output
	input  logic              exe_wb_en,
	input  arm_pkg::reg_idx_t mem_dest,    // ex_mem register output
	input  logic              mem_wb_en,
	output logic              stall
);

	logic exe_hit;                         // RAW against execute
	logic mem_hit;                         // RAW against memory

	// Writeback stage needs no check, the RF writes through
	assign exe_hit = exe_wb_en &&
		((src1_used && (src1 == exe_dest)) ||
		 (src2_used && (src2 == exe_dest)));

	assign mem_hit = mem_wb_en &&
		((src1_used && (src1 == mem_dest)) ||
		 (src2_used && (src2 == mem_dest)));

	assign stall = exe_hit || mem_hit;     // Freeze front, bubble into execute

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            freeze,   // Hazard stall
	output arm_pkg::if_id_t if_out
);

	arm_pkg::word_t pc;                            // Byte address of current fetch
	arm_pkg::word_t rom [arm_pkg::imem_depth];     // Instruction memory
	logic           at_end;                        // On the last ROM word

	initial begin
		$readmemh("program.hex", rom);             // Zero padded to full depth
	end

	assign at_end = (pc == arm_pkg::imem_last_pc);

	// One word per cycle
	// The last word is padding, so parking there only issues no-ops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!freeze && !at_end) begin
			pc <= pc + 4;                          // Next word
		end
	end

	always_comb begin
		if_out.valid = 1'b1;                       // Every fetched word is real
		if_out.pc    = pc;
		if_out.instr = rom[pc[arm_pkg::imem_aw+1:2]]; // Async ROM read
	end

	// PC aligned and inside the ROM for the whole run
	a_pc_in_rom: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pc < arm_pkg::imem_depth * 4) && (pc[1:0] == 2'b00)
	) else $error("PC left the instruction ROM: %h", pc);

endmodule

`default_nettype wire

//--- stage_reg.sv
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic   // Pipeline payload struct
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,     // Keep current contents
	input  logic     bubble,   // Load a no-op
	input  payload_t d,
	output payload_t q
);

	// All-zero payload is a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;                 // Empty pipe out of reset
		end else if (bubble) begin
			q <= '0;                 // Insert no-op
		end else if (!hold) begin
			q <= d;                  // Normal advance
		end
	end

	// Hazard control never asks for both at once
	a_hold_xor_bubble: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(hold && bubble)
	) else $error("stage_reg: hold and bubble both high");

endmodule

`default_nettype wire

//--- arm_pkg.sv
`default_nettype none

package arm_pkg;

	// Datapath and storage sizes
	localparam int xlen       = 32;                    // Data and address width
	localparam int reg_addr_w = 4;                     // Register index width
	localparam int reg_count  = 2 ** reg_addr_w;       // R0..R15
	localparam int imm_w      = 12;                    // Offset field of LDR/STR
	localparam int imem_depth = 64;                    // ROM words
	localparam int dmem_depth = 64;                    // RAM words
	localparam int imem_aw    = $clog2(imem_depth);    // ROM word index bits
	localparam int dmem_aw    = $clog2(dmem_depth);    // RAM word index bits

	typedef logic [xlen-1:0]       word_t;
	typedef logic [reg_addr_w-1:0] reg_idx_t;

	// Last fetch address, PC parks here
	localparam word_t imem_last_pc = word_t'((imem_depth - 1) * 4);

	// Data-processing opcodes, bits 24:21
	typedef enum logic [3:0] {
		op_and = 4'b0000,
		op_eor = 4'b0001,
		op_sub = 4'b0010,
		op_add = 4'b0100,
		op_orr = 4'b1100,
		op_mov = 4'b1101
	} alu_op_e;

	localparam logic [3:0] cond_al  = 4'b1110;        // Always, bits 31:28
	localparam logic [1:0] mode_dp  = 2'b00;          // Bits 27:26, data processing
	localparam logic [1:0] mode_mem = 2'b01;          // Bits 27:26, LDR/STR
	localparam reg_idx_t   pc_reg   = reg_idx_t'(15); // Never a writeback target

	// Fetch to decode
	typedef struct packed {
		logic  valid;           // Real fetched word
		word_t pc;              // Address of instr
		word_t instr;           // Raw encoding
	} if_id_t;

	// Decode to execute
	typedef struct packed {
		logic             wb_en;    // Result goes to RF
		logic             mem_r_en; // LDR
		logic             mem_w_en; // STR
		alu_op_e          alu_op;   // ALU function
		logic             imm_en;   // Second operand from imm
		logic [imm_w-1:0] imm;      // Raw operand2 field
		word_t            val_rn;   // First operand
		word_t            val_rm;   // Rm, or Rd for STR
		reg_idx_t         dest;     // Rd
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic     wb_en;
		logic     mem_r_en;
		logic     mem_w_en;
		word_t    alu_result;   // ALU value or byte address
		word_t    st_val;       // Store data
		reg_idx_t dest;
	} ex_mem_t;

	// Memory to writeback
	typedef struct packed {
		logic     wb_en;
		logic     mem_r_en;     // Selects mem_data at writeback
		word_t    alu_result;
		word_t    mem_data;     // Load data
		reg_idx_t dest;
	} mem_wb_t;

	// Writeback event seen at the top
	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    value;
	} retire_t;

endpackage

`default_nettype wire
